/* hw/alu_defines.svh */
// Width constants for the integer execution stage.
// XLEN is fixed at 64; the shifter derives its 6-bit shift amount from it.
// PC, register index and tag widths must match the issue and write-back side.

`ifndef ALU_DEFINES_SVH
`define ALU_DEFINES_SVH

// ---------------------------------------------------------------------------
// Datapath
// ---------------------------------------------------------------------------

// Integer register and operand width
`define ALU_XLEN 64

// Virtual PC width carried to write-back
`define ALU_PC_W 40

// ---------------------------------------------------------------------------
// Bookkeeping
// ---------------------------------------------------------------------------

// Architectural register index, x0..x31
`define ALU_REG_W 5

// Reorder buffer tag
`define ALU_TAG_W 6

`endif

/* hw/alu_pkg.sv */
// Types shared by the execution stage and its testbench.
// Operation codes are 5 bits wide; the unit field decides if the result is kept.
// Only UNIT_ALU and UNIT_SYSTEM are served, UNIT_OTHER is dropped by the stage.

`include "alu_defines.svh"

package alu_pkg;

    // -----------------------------------------------------------------------
    // Scalar field types
    // -----------------------------------------------------------------------

    typedef logic [`ALU_XLEN-1:0]  data_t;
    typedef logic [`ALU_PC_W-1:0]  pc_t;
    typedef logic [`ALU_REG_W-1:0] reg_idx_t;
    typedef logic [`ALU_TAG_W-1:0] tag_t;

    // -----------------------------------------------------------------------
    // Operation codes
    // -----------------------------------------------------------------------

    typedef enum logic [4:0] {
        ADD,
        SUB,
        ADDW,
        SUBW,
        ADDUW,
        SH1ADD,
        SH2ADD,
        SH3ADD,
        SH1ADDUW,
        SH2ADDUW,
        SH3ADDUW,
        SLL,
        SRL,
        SRA,
        SLLW,
        SRLW,
        SRAW,
        SLLIUW,
        SLT,
        SLTU,
        AND_OP,
        OR_OP,
        XOR_OP,
        ZEXTW,
        NOP
    } alu_op_e;

    // Target functional unit
    typedef enum logic [1:0] {
        UNIT_ALU,
        UNIT_SYSTEM,
        UNIT_OTHER
    } exe_unit_e;

    // -----------------------------------------------------------------------
    // Instruction payloads
    // -----------------------------------------------------------------------

    // Register-read to execute, operands already read
    typedef struct packed {
        alu_op_e   op;
        exe_unit_e unit;
        pc_t       pc;
        reg_idx_t  rd;
        logic      regfile_we;
        tag_t      tag;
        data_t     data_rs1;
        data_t     data_rs2;
    } rr_exe_instr_t;

    // Execute to write-back
    typedef struct packed {
        alu_op_e  op;
        pc_t      pc;
        reg_idx_t rd;
        logic     regfile_we;
        tag_t     tag;
        data_t    result;
    } exe_wb_instr_t;

endpackage

/* hw/alu_add.sv */
// Full-width adder and subtractor.
// Operands arrive already extended and pre-shifted; word results are
// narrowed and sign extended by the caller.

`timescale 1ns/1ns

module alu_add
    import alu_pkg::*;
(
    input  alu_op_e op_i,
    input  data_t   a_i,
    input  data_t   b_i,
    output data_t   sum_o
);

    logic  sub;
    data_t b_eff;

    // Subtract as a + ~b + 1
    always_comb begin
        case (op_i)
            SUB, SUBW: begin
                sub = 1'b1;
            end
            default: begin
                sub = 1'b0;
            end
        endcase
    end

    assign b_eff = sub ? ~b_i : b_i;

    // Carry out dropped, result is modulo 2^XLEN
    assign sum_o = a_i + b_eff + data_t'(sub);

endmodule

/* hw/alu_shift.sv */
// Barrel shifter for left, logical right and arithmetic right shifts.
// Full-width shifts and SLLIUW use the low 6 bits of b_i, word shifts the low 5.
// a_i must already be zero or sign extended for the word forms.

`timescale 1ns/1ns

module alu_shift
    import alu_pkg::*;
(
    input  alu_op_e op_i,
    input  data_t   a_i,
    input  data_t   b_i,
    output data_t   shifted_o
);

    localparam int SHAMT_W = $clog2($bits(data_t));

    logic [SHAMT_W-1:0] shamt;

    // Shift amount masking
    always_comb begin
        case (op_i)
            SLLW, SRLW, SRAW: begin
                shamt = {1'b0, b_i[SHAMT_W-2:0]};
            end
            default: begin
                shamt = b_i[SHAMT_W-1:0];
            end
        endcase
    end

    always_comb begin
        case (op_i)
            SLL, SLLW, SLLIUW: begin
                shifted_o = a_i << shamt;
            end
            SRL, SRLW: begin
                shifted_o = a_i >> shamt;
            end
            SRA, SRAW: begin
                // Sign of a_i fills from the top
                shifted_o = $signed(a_i) >>> shamt;
            end
            default: begin
                shifted_o = '0;
            end
        endcase
    end

endmodule

/* hw/alu.sv */
// Combinational integer ALU for RV64I and the Zba address operations.
// Instructions for units other than ALU and SYSTEM produce keep_o low and a
// zero result. A SYSTEM instruction returns rs1 whatever its op code.

`timescale 1ns/1ns

module alu
    import alu_pkg::*;
(
    input  rr_exe_instr_t instr_i,
    output exe_wb_instr_t instr_o,
    output logic          keep_o
);

    data_t rs1;
    data_t rs2;
    data_t rs1_ext;
    data_t rs1_pre;
    data_t add_res;
    data_t shift_res;
    data_t cmp_res;
    data_t logic_res;
    data_t op_res;
    data_t result;

    assign rs1 = instr_i.data_rs1;
    assign rs2 = instr_i.data_rs2;

    // -----------------------------------------------------------------------
    // Operand preparation
    // -----------------------------------------------------------------------

    // Zero or sign extension of the low word of rs1
    always_comb begin
        case (instr_i.op)
            ADDUW, SH1ADDUW, SH2ADDUW, SH3ADDUW, ZEXTW, SLLIUW, SLLW, SRLW: begin
                rs1_ext = {32'b0, rs1[31:0]};
            end
            SRAW: begin
                rs1_ext = {{32{rs1[31]}}, rs1[31:0]};
            end
            default: begin
                rs1_ext = rs1;
            end
        endcase
    end

    // Pre-shift for shNadd, upper bits fall off
    always_comb begin
        case (instr_i.op)
            SH1ADD, SH1ADDUW: rs1_pre = rs1_ext << 1;
            SH2ADD, SH2ADDUW: rs1_pre = rs1_ext << 2;
            SH3ADD, SH3ADDUW: rs1_pre = rs1_ext << 3;
            default:          rs1_pre = rs1_ext;
        endcase
    end

    alu_add add0 (
        .op_i  (instr_i.op),
        .a_i   (rs1_pre),
        .b_i   (rs2),
        .sum_o (add_res)
    );

    alu_shift shift0 (
        .op_i      (instr_i.op),
        .a_i       (rs1_ext),
        .b_i       (rs2),
        .shifted_o (shift_res)
    );

    // Compare and logic
    assign cmp_res = (instr_i.op == SLT) ? data_t'($signed(rs1) < $signed(rs2))
                                         : data_t'(rs1 < rs2);

    always_comb begin
        case (instr_i.op)
            AND_OP:  logic_res = rs1 & rs2;
            OR_OP:   logic_res = rs1 | rs2;
            default: logic_res = rs1 ^ rs2;
        endcase
    end

    // -----------------------------------------------------------------------
    // Result select
    // -----------------------------------------------------------------------

    always_comb begin
        case (instr_i.op)
            ADD, SUB, ADDUW, SH1ADD, SH2ADD, SH3ADD, SH1ADDUW, SH2ADDUW, SH3ADDUW: begin
                op_res = add_res;
            end
            ADDW, SUBW: begin
                op_res = {{32{add_res[31]}}, add_res[31:0]};
            end
            SLL, SRL, SRA, SLLIUW: begin
                op_res = shift_res;
            end
            SLLW, SRLW, SRAW: begin
                op_res = {{32{shift_res[31]}}, shift_res[31:0]};
            end
            SLT, SLTU: begin
                op_res = cmp_res;
            end
            AND_OP, OR_OP, XOR_OP: begin
                op_res = logic_res;
            end
            ZEXTW: begin
                op_res = rs1_ext;
            end
            default: begin
                op_res = '0;
            end
        endcase
    end

    // SYSTEM passes rs1, dropped units give zero
    always_comb begin
        case (instr_i.unit)
            UNIT_ALU:    result = op_res;
            UNIT_SYSTEM: result = rs1;
            default:     result = '0;
        endcase
    end

    assign keep_o = (instr_i.unit == UNIT_ALU) || (instr_i.unit == UNIT_SYSTEM);

    // Metadata to write-back
    always_comb begin
        instr_o.op         = instr_i.op;
        instr_o.pc         = instr_i.pc;
        instr_o.rd         = instr_i.rd;
        instr_o.regfile_we = instr_i.regfile_we;
        instr_o.tag        = instr_i.tag;
        instr_o.result     = result;
    end

    // Decode never routes a NOP to the ALU unit
    a_no_alu_nop: assert final ($isunknown({instr_i.unit, instr_i.op}) ||
                                !(instr_i.unit == UNIT_ALU && instr_i.op == NOP))
        else $error("alu: NOP issued to UNIT_ALU");

endmodule

/* hw/pipe_reg.sv */
// One-entry valid/ready pipeline register.
// Accepts when empty or when its item leaves in the same cycle.
// Only the valid bit is reset; the payload is undefined until first load.

`timescale 1ns/1ns

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     in_valid_i,
    output logic     in_ready_o,
    input  payload_t in_data_i,
    output logic     out_valid_o,
    input  logic     out_ready_i,
    output payload_t out_data_o
);

    logic     valid_q;
    payload_t data_q;

    assign in_ready_o = !valid_q || out_ready_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (in_ready_o) begin
            valid_q <= in_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_valid_i && in_ready_o) begin
            data_q <= in_data_i;
        end
    end

    assign out_valid_o = valid_q;
    assign out_data_o  = data_q;

    // Stalled item holds until taken
    a_hold_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o))
        else $error("pipe_reg: output changed while stalled");

    a_valid_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !$isunknown(out_valid_o))
        else $error("pipe_reg: out_valid_o is X");

endmodule

/* hw/alu_exe_top.sv */
// Integer execution stage: input register, ALU, output register.
// Kept instructions leave in arrival order; UNIT_OTHER is accepted and dropped.
// Inputs must stay stable while in_valid_i is high and in_ready_o is low.

`timescale 1ns/1ns

`include "alu_defines.svh"

module alu_exe_top
    import alu_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_n_i,

    // Issue side
    input  logic                  in_valid_i,
    output logic                  in_ready_o,
    input  alu_op_e               op_i,
    input  exe_unit_e             unit_i,
    input  logic [`ALU_PC_W-1:0]  pc_i,
    input  logic [`ALU_REG_W-1:0] rd_i,
    input  logic                  regfile_we_i,
    input  logic [`ALU_TAG_W-1:0] tag_i,
    input  logic [`ALU_XLEN-1:0]  rs1_i,
    input  logic [`ALU_XLEN-1:0]  rs2_i,

    // Write-back side
    output logic                  out_valid_o,
    input  logic                  out_ready_i,
    output alu_op_e               out_op_o,
    output logic [`ALU_PC_W-1:0]  out_pc_o,
    output logic [`ALU_REG_W-1:0] out_rd_o,
    output logic                  out_regfile_we_o,
    output logic [`ALU_TAG_W-1:0] out_tag_o,
    output logic [`ALU_XLEN-1:0]  out_result_o
);

    rr_exe_instr_t in_pkt;
    rr_exe_instr_t rr_pkt;
    exe_wb_instr_t alu_pkt;
    exe_wb_instr_t wb_pkt;
    logic          rr_valid;
    logic          rr_ready;
    logic          keep;
    logic          wb_in_valid;
    logic          wb_in_ready;

    assign in_pkt = '{op: op_i, unit: unit_i, pc: pc_i, rd: rd_i, regfile_we: regfile_we_i,
                      tag: tag_i, data_rs1: rs1_i, data_rs2: rs2_i};

    pipe_reg #(.payload_t(rr_exe_instr_t)) rr_q (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .in_data_i   (in_pkt),
        .out_valid_o (rr_valid),
        .out_ready_i (rr_ready),
        .out_data_o  (rr_pkt)
    );

    alu alu0 (
        .instr_i (rr_pkt),
        .instr_o (alu_pkt),
        .keep_o  (keep)
    );

    // Dropped instructions drain from rr_q without entering wb_q
    assign wb_in_valid = rr_valid & keep;
    assign rr_ready    = wb_in_ready | ~keep;

    pipe_reg #(.payload_t(exe_wb_instr_t)) wb_q (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .in_valid_i  (wb_in_valid),
        .in_ready_o  (wb_in_ready),
        .in_data_i   (alu_pkt),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .out_data_o  (wb_pkt)
    );

    assign out_op_o         = wb_pkt.op;
    assign out_pc_o         = wb_pkt.pc;
    assign out_rd_o         = wb_pkt.rd;
    assign out_regfile_we_o = wb_pkt.regfile_we;
    assign out_tag_o        = wb_pkt.tag;
    assign out_result_o     = wb_pkt.result;

endmodule

/* bench/tb_alu_exe.sv */
// Testbench for the integer execution stage, driven on the falling clock edge.
// The first half holds out_ready_i high and checks the 2-cycle latency. The
// second half toggles out_ready_i at random and checks stall behavior.

`timescale 1ns/1ns

`include "alu_defines.svh"

module tb_alu_exe
    import alu_pkg::*;
();

    localparam int CLK_PERIOD = 20;
    localparam int SAMPLE_DLY = 8;
    localparam int NUM_INSTR  = 600;
    localparam int WATCHDOG   = NUM_INSTR * 8 * CLK_PERIOD;

    // Expected write-back item, tagged with its acceptance edge
    typedef struct {
        exe_wb_instr_t wb;
        int unsigned   acc_edge;
        bit            chk_lat;
    } exp_t;

    logic                  clk_i;
    logic                  rst_n_i;
    logic                  in_valid_i;
    logic                  in_ready_o;
    alu_op_e               op_i;
    exe_unit_e             unit_i;
    logic [`ALU_PC_W-1:0]  pc_i;
    logic [`ALU_REG_W-1:0] rd_i;
    logic                  regfile_we_i;
    logic [`ALU_TAG_W-1:0] tag_i;
    logic [`ALU_XLEN-1:0]  rs1_i;
    logic [`ALU_XLEN-1:0]  rs2_i;
    logic                  out_valid_o;
    logic                  out_ready_i;
    alu_op_e               out_op_o;
    logic [`ALU_PC_W-1:0]  out_pc_o;
    logic [`ALU_REG_W-1:0] out_rd_o;
    logic                  out_regfile_we_o;
    logic [`ALU_TAG_W-1:0] out_tag_o;
    logic [`ALU_XLEN-1:0]  out_result_o;

    integer                seed;
    int                    err_data = 0;
    int                    err_proto = 0;
    int unsigned           edge_cnt = 0;
    int unsigned           n_acc = 0;
    int unsigned           n_kept = 0;
    logic [`ALU_TAG_W-1:0] next_tag;
    exp_t                  exp_q[$];

    alu_exe_top dut0 (.*);

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD/2) clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        edge_cnt <= edge_cnt + 1;
    end

    // -------------------------------------------------------------------------
    // Reference model
    // -------------------------------------------------------------------------

    function automatic logic [63:0] ref_result(input alu_op_e op, input exe_unit_e unit,
                                               input logic [63:0] rs1, input logic [63:0] rs2);
        logic [63:0] zx;
        logic [31:0] w;
        logic [63:0] r;
        zx = {32'h0, rs1[31:0]};
        w = '0;
        r = '0;
        case (op)
            ADD:      r = rs1 + rs2;
            SUB:      r = rs1 - rs2;
            ADDUW:    r = zx + rs2;
            SH1ADD:   r = (rs1 << 1) + rs2;
            SH2ADD:   r = (rs1 << 2) + rs2;
            SH3ADD:   r = (rs1 << 3) + rs2;
            SH1ADDUW: r = (zx << 1) + rs2;
            SH2ADDUW: r = (zx << 2) + rs2;
            SH3ADDUW: r = (zx << 3) + rs2;
            SLL:      r = rs1 << rs2[5:0];
            SRL:      r = rs1 >> rs2[5:0];
            SRA:      r = $signed(rs1) >>> rs2[5:0];
            SLLIUW:   r = zx << rs2[5:0];
            SLT:      r = {63'h0, $signed(rs1) < $signed(rs2)};
            SLTU:     r = {63'h0, rs1 < rs2};
            AND_OP:   r = rs1 & rs2;
            OR_OP:    r = rs1 | rs2;
            XOR_OP:   r = rs1 ^ rs2;
            ZEXTW:    r = zx;
            ADDW:     w = rs1[31:0] + rs2[31:0];
            SUBW:     w = rs1[31:0] - rs2[31:0];
            SLLW:     w = rs1[31:0] << rs2[4:0];
            SRLW:     w = rs1[31:0] >> rs2[4:0];
            SRAW:     w = $signed(rs1[31:0]) >>> rs2[4:0];
            default:  r = '0;
        endcase
        // Word forms sign extend bit 31
        if (op inside {ADDW, SUBW, SLLW, SRLW, SRAW}) begin
            r = {{32{w[31]}}, w};
        end
        if (unit == UNIT_SYSTEM) begin
            r = rs1;
        end else if (unit != UNIT_ALU) begin
            r = '0;
        end
        return r;
    endfunction

    // Low word biased to the sign boundary now and then
    function automatic logic [63:0] rand_operand();
        logic [31:0] sel;
        logic [63:0] v;
        sel = $random(seed);
        v = {$random(seed), $random(seed)};
        case (sel % 8)
            0:       v[31:0] = 32'h7fff_ffff;
            1:       v[31:0] = 32'h8000_0000;
            2:       v = '1;
            default: ;
        endcase
        return v;
    endfunction

    function automatic exe_wb_instr_t out_snapshot();
        return '{op: out_op_o, pc: out_pc_o, rd: out_rd_o, regfile_we: out_regfile_we_o,
                 tag: out_tag_o, result: out_result_o};
    endfunction

    task automatic check_field(input string name, input logic [63:0] exp_v,
                               input logic [63:0] act_v);
        assert (act_v === exp_v) else begin
            $display("FAIL %s expected 0x%h got 0x%h", name, exp_v, act_v);
            err_data++;
        end
    endtask

    // -------------------------------------------------------------------------
    // Stimulus
    // -------------------------------------------------------------------------

    task automatic load_random_instr();
        logic [31:0] rnd;
        logic [63:0] wide;
        rnd = $random(seed);
        case (rnd[3:0])
            0, 1:    unit_i = UNIT_OTHER;
            2:       unit_i = UNIT_SYSTEM;
            default: unit_i = UNIT_ALU;
        endcase
        rnd = $random(seed);
        // NOP only outside the ALU unit
        op_i = (unit_i == UNIT_ALU) ? alu_op_e'(5'(rnd % 24)) : alu_op_e'(5'(rnd % 25));
        wide = {$random(seed), $random(seed)};
        pc_i = wide[`ALU_PC_W-1:0];
        rd_i = rnd[`ALU_REG_W+7:8];
        regfile_we_i = rnd[20];
        tag_i = next_tag;
        next_tag = next_tag + 1'b1;
        rs1_i = rand_operand();
        rs2_i = rand_operand();
    endtask

    task automatic record_accept(input bit chk_lat);
        exp_t e;
        n_acc++;
        if (unit_i != UNIT_OTHER) begin
            e.wb = '{op: op_i, pc: pc_i, rd: rd_i, regfile_we: regfile_we_i, tag: tag_i,
                     result: ref_result(op_i, unit_i, rs1_i, rs2_i)};
            e.acc_edge = edge_cnt + 1;
            e.chk_lat = chk_lat;
            exp_q.push_back(e);
            n_kept++;
        end
    endtask

    task automatic run_phase(input int n, input bit stalls);
        int          issued;
        bit          pending;
        logic [31:0] rnd;
        issued = 0;
        pending = 1'b0;
        while (issued < n) begin
            @(negedge clk_i);
            rnd = $random(seed);
            out_ready_i = stalls ? rnd[0] : 1'b1;
            if (!pending) begin
                pending = (rnd[4:2] != 3'b000);
                in_valid_i = pending;
                if (pending) begin
                    load_random_instr();
                end
            end
            #(SAMPLE_DLY);
            if (in_valid_i && in_ready_o) begin
                record_accept(!stalls);
                pending = 1'b0;
                issued++;
            end
        end
    endtask

    // Empty the stage, then a few idle cycles to catch stray outputs
    task automatic drain_outputs();
        @(negedge clk_i);
        in_valid_i = 1'b0;
        out_ready_i = 1'b1;
        while (exp_q.size() != 0) begin
            @(negedge clk_i);
        end
        repeat (4) @(negedge clk_i);
    endtask

    task automatic print_summary();
        $display("Summary: %0d accepted, %0d kept, %0d data errors, %0d protocol errors",
                 n_acc, n_kept, err_data, err_proto);
    endtask

    initial begin
        seed = 32'h77a5;
        next_tag = '0;
        rst_n_i = 1'b0;
        in_valid_i = 1'b0;
        out_ready_i = 1'b0;
        op_i = ADD;
        unit_i = UNIT_ALU;
        pc_i = '0;
        rd_i = '0;
        regfile_we_i = 1'b0;
        tag_i = '0;
        rs1_i = '0;
        rs2_i = '0;
        repeat (8) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        #(SAMPLE_DLY);
        check_field("out_valid_o", 64'h0, out_valid_o);
        check_field("in_ready_o", 64'h1, in_ready_o);
        run_phase(NUM_INSTR/2, 1'b0);
        drain_outputs();
        run_phase(NUM_INSTR/2, 1'b1);
        drain_outputs();
        print_summary();
        if (err_data + err_proto == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // -------------------------------------------------------------------------
    // Scoreboard
    // -------------------------------------------------------------------------

    initial begin : compare_outputs
        exp_t          e;
        exe_wb_instr_t held;
        logic          stalled;
        stalled = 1'b0;
        held = '0;
        wait (rst_n_i === 1'b1);
        forever begin
            @(negedge clk_i);
            #(SAMPLE_DLY);
            if (stalled) begin
                assert (out_valid_o && out_snapshot() === held) else begin
                    $display("Output dropped or changed while out_ready_i was low");
                    err_proto++;
                end
            end
            stalled = out_valid_o && !out_ready_i;
            held = out_snapshot();
            if (out_valid_o && out_ready_i) begin
                assert (exp_q.size() != 0) else begin
                    $display("Output with tag %0d appeared with nothing expected", out_tag_o);
                    err_proto++;
                end
                if (exp_q.size() != 0) begin
                    e = exp_q.pop_front();
                    check_field("out_tag_o", e.wb.tag, out_tag_o);
                    check_field("out_op_o", e.wb.op, out_op_o);
                    check_field("out_pc_o", e.wb.pc, out_pc_o);
                    check_field("out_rd_o", e.wb.rd, out_rd_o);
                    check_field("out_regfile_we_o", e.wb.regfile_we, out_regfile_we_o);
                    check_field("out_result_o", e.wb.result, out_result_o);
                    assert (!e.chk_lat || edge_cnt + 1 == e.acc_edge + 2) else begin
                        $display("Tag %0d left %0d cycles after acceptance instead of 2",
                                 e.wb.tag, edge_cnt + 1 - e.acc_edge);
                        err_proto++;
                    end
                end
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG);
        $display("Simulation hung: stage did not finish within %0d ns", WATCHDOG);
        err_proto++;
        print_summary();
        $display("TESTS FAILED");
        $finish;
    end

endmodule

/* flist.f */
+incdir+hw
hw/alu_pkg.sv
hw/alu_add.sv
hw/alu_shift.sv
hw/alu.sv
hw/pipe_reg.sv
hw/alu_exe_top.sv
bench/tb_alu_exe.sv

/* Bender.yml */
package:
  name: alu_exe

export_include_dirs:
  - hw

sources:
  - files:
      - hw/alu_pkg.sv
      - hw/alu_add.sv
      - hw/alu_shift.sv
      - hw/alu.sv
      - hw/pipe_reg.sv
      - hw/alu_exe_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - bench/tb_alu_exe.sv
